/* drone_esc_pwm.f */
src/pwm_timing_pkg.sv
src/esc_regs_pkg.sv
src/axil_rate_regs.sv
src/rate_shadow_buffer.sv
src/pwm_frame_timer.sv
src/pwm_channel.sv
src/esc_pwm_top.sv
verification/esc_pwm_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the ESC PWM testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
  --top-module esc_pwm_tb \
  -f drone_esc_pwm.f \
  -o esc_pwm_sim

sim_out=$(./obj_dir/esc_pwm_sim 2>&1 || true)
echo "$sim_out"

if echo "$sim_out" | grep -qx "SIMULATION PASSED"; then
  exit 0
else
  exit 1
fi

/* verification/esc_pwm_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module esc_pwm_tb
  import esc_regs_pkg::*;
();

  // Shortened frame for simulation
  localparam int period = 1100;
  localparam int min_high = 60;
  // Twelve frames plus margin for the register traffic
  localparam int cycle_limit = 12 * period + 2000;
  localparam int handshake_limit = 20;

  logic        us_clk;
  logic        resetn;
  logic        awvalid;
  logic        awready;
  axil_aw_t    aw;
  logic        wvalid;
  logic        wready;
  axil_w_t     w;
  logic        bvalid;
  logic        bready;
  axil_resp_e  bresp;
  logic        arvalid;
  logic        arready;
  axil_ar_t    ar;
  logic        rvalid;
  logic        rready;
  logic [31:0] rdata;
  axil_resp_e  rresp;
  logic [3:0]  motor_pwm;

  // Staged register model, kept by the bus tasks
  logic [7:0]  model_rate [4];
  logic        model_armed;
  // Frame position and frame count models
  int          pos_m;
  logic [31:0] frame_model;
  int          cycle_count = 0;
  logic [31:0] rng_state;
  // Expected responses of the transaction in flight
  axil_resp_e  exp_bresp;
  axil_resp_e  exp_rresp;
  logic [31:0] exp_rdata;

  // Pulse measurement state
  int          hi_cnt [4] = '{0, 0, 0, 0};
  int          last_rise [4] = '{0, 0, 0, 0};
  logic [3:0]  rose_now = '0;
  logic [3:0]  rose_prev = '0;
  logic [3:0]  prev_pwm = '0;
  int          rise_total = 0;
  logic [7:0]  cur_rate [4] = '{8'd0, 8'd0, 8'd0, 8'd0};
  logic [7:0]  next_rate [4] = '{8'd0, 8'd0, 8'd0, 8'd0};
  logic        cur_armed = 1'b0;
  logic        next_armed = 1'b0;

  esc_pwm_top #(
    .period_us   (period),
    .min_high_us (min_high)
  ) DUT (
    .us_clk    (us_clk),
    .resetn    (resetn),
    .awvalid   (awvalid),
    .awready   (awready),
    .aw        (aw),
    .wvalid    (wvalid),
    .wready    (wready),
    .w         (w),
    .bvalid    (bvalid),
    .bready    (bready),
    .bresp     (bresp),
    .arvalid   (arvalid),
    .arready   (arready),
    .ar        (ar),
    .rvalid    (rvalid),
    .rready    (rready),
    .rdata     (rdata),
    .rresp     (rresp),
    .motor_pwm (motor_pwm)
  );

  initial begin
    us_clk = 1'b0;
    forever #5 us_clk = ~us_clk;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic draw_random(output logic [31:0] v);
    rng_state = lcg_next(rng_state);
    v = rng_state;
  endtask

  // Writable registers only, status is read-only
  function automatic bit write_mapped(input logic [31:0] addr);
    return addr inside {32'h00, 32'h04, 32'h08, 32'h0C, 32'h10};
  endfunction

  function automatic bit read_mapped(input logic [31:0] addr);
    return addr inside {32'h00, 32'h04, 32'h08, 32'h0C, 32'h10, 32'h14};
  endfunction

  task automatic update_model(input logic [31:0] addr, input logic [31:0] data);
    case (addr)
      32'h00: model_rate[0] = data[7:0];
      32'h04: model_rate[1] = data[7:0];
      32'h08: model_rate[2] = data[7:0];
      32'h0C: model_rate[3] = data[7:0];
      32'h10: model_armed = data[0];
      default: ;
    endcase
  endtask

  function automatic logic [31:0] expected_read(input logic [31:0] addr);
    case (addr)
      32'h00: return {24'h0, model_rate[0]};
      32'h04: return {24'h0, model_rate[1]};
      32'h08: return {24'h0, model_rate[2]};
      32'h0C: return {24'h0, model_rate[3]};
      32'h10: return {31'h0, model_armed};
      32'h14: return frame_model;
      default: return 32'h0;
    endcase
  endfunction

  // Single write, response taken after a random stall
  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] r;
    int          stall;
    int          waited;
    draw_random(r);
    stall = int'(r[29:28]);
    waited = 0;
    @(posedge us_clk);
    #1;
    aw.addr = addr;
    w.data = data;
    awvalid = 1'b1;
    wvalid = 1'b1;
    exp_bresp = write_mapped(addr) ? OKAY : SLVERR;
    do begin
      @(negedge us_clk);
      waited++;
    end while (!(awready && wready) && waited < handshake_limit);
    if (!(awready && wready)) begin
      report_failure($sformatf("Write to 0x%08h was never accepted", addr));
    end else begin
      // Handshake on this edge, staged register follows
      @(posedge us_clk);
      #1;
      awvalid = 1'b0;
      wvalid = 1'b0;
      update_model(addr, data);
      repeat (stall) begin
        @(posedge us_clk);
        #1;
      end
      bready = 1'b1;
      waited = 0;
      while (!bvalid && waited < handshake_limit) begin
        @(negedge us_clk);
        waited++;
      end
      if (!bvalid) begin
        report_failure($sformatf("No write response for address 0x%08h", addr));
      end else begin
        @(posedge us_clk);
        #1;
        bready = 1'b0;
      end
    end
  endtask

  // Single read, data taken after a random stall
  task automatic axil_read(input logic [31:0] addr, output logic [31:0] data);
    logic [31:0] r;
    int          stall;
    int          waited;
    draw_random(r);
    stall = int'(r[29:28]);
    waited = 0;
    @(posedge us_clk);
    #1;
    ar.addr = addr;
    arvalid = 1'b1;
    do begin
      @(negedge us_clk);
      waited++;
    end while (!arready && waited < handshake_limit);
    if (!arready) begin
      report_failure($sformatf("Read from 0x%08h was never accepted", addr));
    end else begin
      // Model value as the DUT captures it on the coming edge
      exp_rdata = expected_read(addr);
      exp_rresp = read_mapped(addr) ? OKAY : SLVERR;
      @(posedge us_clk);
      #1;
      arvalid = 1'b0;
      repeat (stall) begin
        @(posedge us_clk);
        #1;
      end
      rready = 1'b1;
      waited = 0;
      while (!rvalid && waited < handshake_limit) begin
        @(negedge us_clk);
        waited++;
      end
      if (!rvalid) begin
        report_failure($sformatf("No read data for address 0x%08h", addr));
      end else begin
        data = rdata;
        @(posedge us_clk);
        #1;
        rready = 1'b0;
      end
    end
  endtask

  // Returns on count 1, right after a frame is scored
  task automatic wait_frames(input int n);
    repeat (n) begin
      do @(negedge us_clk); while (pos_m != 1);
    end
  endtask

  task automatic wait_position(input int p);
    do @(negedge us_clk); while (pos_m != p);
  endtask

  // Frame position and frame count, same rule as the timer
  always @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      pos_m <= 0;
      frame_model <= '0;
    end else begin
      pos_m <= (pos_m == period - 1) ? 0 : pos_m + 1;
      if (pos_m == 0) begin
        frame_model <= frame_model + 32'd1;
      end
    end
  end

  always @(posedge us_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      report_failure($sformatf("Timeout after %0d cycles, test sequence stuck", cycle_count));
    end
  end

  // Responses hold until taken
  assert property (@(posedge us_clk) disable iff (!resetn) bvalid && !bready |=> bvalid)
    else report_failure($sformatf("** Error at %0t: bvalid expected 1, got %0b", $time, bvalid));
  assert property (@(posedge us_clk) disable iff (!resetn) rvalid && !rready |=> rvalid)
    else report_failure($sformatf("** Error at %0t: rvalid expected 1, got %0b", $time, rvalid));
  assert property (@(posedge us_clk) disable iff (!resetn) rvalid && !rready |=> $stable(rdata))
    else report_failure($sformatf("** Error at %0t: rdata changed while stalled, got 0x%08h",
                                  $time, rdata));

  // Response contents against the register model
  assert property (@(posedge us_clk) disable iff (!resetn) bvalid && bready |-> bresp == exp_bresp)
    else report_failure($sformatf("** Error at %0t: bresp expected %b, got %b",
                                  $time, exp_bresp, bresp));
  assert property (@(posedge us_clk) disable iff (!resetn) rvalid && rready |-> rresp == exp_rresp)
    else report_failure($sformatf("** Error at %0t: rresp expected %b, got %b",
                                  $time, exp_rresp, rresp));
  assert property (@(posedge us_clk) disable iff (!resetn) rvalid && rready |-> rdata == exp_rdata)
    else report_failure($sformatf("** Error at %0t: rdata expected 0x%08h, got 0x%08h",
                                  $time, exp_rdata, rdata));

  // Pulse width and spacing, sampled mid-cycle
  // Port shows the count before, so a pulse spans counts 2 to width+1
  always @(negedge us_clk) begin : measure
    int exp_w;
    if (resetn) begin
      if (pos_m == 0) begin
        // Staged values taken at frame start
        next_rate = model_rate;
        next_armed = model_armed;
      end
      if (pos_m == 1) begin
        for (int i = 0; i < 4; i++) begin
          exp_w = cur_armed ? min_high + 4 * int'(cur_rate[i]) : 0;
          assert (hi_cnt[i] == exp_w)
            else report_failure($sformatf("** Error at %0t: motor_pwm[%0d] high cycles expected %0d, got %0d",
                                          $time, i, exp_w, hi_cnt[i]));
          hi_cnt[i] = 0;
          rose_prev[i] = rose_now[i];
          rose_now[i] = 1'b0;
        end
        cur_rate = next_rate;
        cur_armed = next_armed;
      end
      for (int i = 0; i < 4; i++) begin
        if (motor_pwm[i]) begin
          hi_cnt[i]++;
        end
        if (motor_pwm[i] && !prev_pwm[i]) begin
          // Back-to-back armed frames rise one period apart
          assert (!rose_prev[i] || cycle_count - last_rise[i] == period)
            else report_failure($sformatf("** Error at %0t: motor_pwm[%0d] edge spacing expected %0d, got %0d",
                                          $time, i, period, cycle_count - last_rise[i]));
          last_rise[i] = cycle_count;
          rose_now[i] = 1'b1;
          if (i == 0) begin
            rise_total++;
          end
        end
      end
      prev_pwm = motor_pwm;
    end
  end

  initial begin
    logic [31:0] r;
    logic [31:0] rd;
    logic [31:0] status_a;
    logic [31:0] status_b;
    int          rises_a;
    resetn = 1'b0;
    awvalid = 1'b0;
    wvalid = 1'b0;
    bready = 1'b0;
    arvalid = 1'b0;
    rready = 1'b0;
    aw = '0;
    w = '0;
    ar = '0;
    model_rate = '{8'd0, 8'd0, 8'd0, 8'd0};
    model_armed = 1'b0;
    rng_state = 32'h897d;
    exp_bresp = OKAY;
    exp_rresp = OKAY;
    exp_rdata = '0;
    repeat (16) @(posedge us_clk);
    #1;
    resetn = 1'b1;

    // Random rates, then arm
    for (int i = 0; i < 4; i++) begin
      draw_random(r);
      axil_write(32'(4 * i), {24'h0, r[23:16]});
    end
    axil_write(32'h10, 32'h1);
    for (int i = 0; i < 5; i++) begin
      axil_read(32'(4 * i), rd);
    end

    // Status write, unmapped write and read
    axil_write(32'h14, 32'hDEAD_BEEF);
    axil_write(32'h20, 32'h0000_005A);
    axil_read(32'h20, rd);
    // Model untouched, registers must agree
    for (int i = 0; i < 6; i++) begin
      axil_read(32'(4 * i), rd);
    end
    wait_frames(2);

    // New rates mid-frame, current pulse keeps old width
    // Rate of 128 or more reaches past count 500, so an early update would show
    wait_position(500);
    for (int i = 0; i < 4; i++) begin
      draw_random(r);
      axil_write(32'(4 * i), {24'h0, 1'b1, r[22:16]});
    end
    wait_frames(2);

    // Disarm, then re-arm
    axil_write(32'h10, 32'h0);
    wait_frames(2);
    axil_write(32'h10, 32'h1);

    // Frame counter against motor 1 edges, sampled mid-frame
    wait_position(300);
    axil_read(32'h14, status_a);
    rises_a = rise_total;
    wait_frames(2);
    wait_position(300);
    axil_read(32'h14, status_b);
    assert (status_b - status_a == 32'(rise_total - rises_a))
      else report_failure($sformatf("** Error at %0t: frame_count delta expected %0d, got %0d",
                                    $time, rise_total - rises_a, status_b - status_a));
    wait_frames(1);
    @(posedge us_clk);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* src/esc_pwm_top.sv */
`timescale 1ns/1ps
`default_nettype none

module esc_pwm_top
  import pwm_timing_pkg::*, esc_regs_pkg::*;
#(
  parameter int period_us   = default_period_us,
  parameter int min_high_us = default_min_high_us
) (
  input  logic                       us_clk,
  input  logic                       resetn,
  input  logic                       awvalid,
  output logic                       awready,
  input  axil_aw_t                   aw,
  input  logic                       wvalid,
  output logic                       wready,
  input  axil_w_t                    w,
  output logic                       bvalid,
  input  logic                       bready,
  output axil_resp_e                 bresp,
  input  logic                       arvalid,
  output logic                       arready,
  input  axil_ar_t                   ar,
  output logic                       rvalid,
  input  logic                       rready,
  output logic [axil_data_width-1:0] rdata,
  output axil_resp_e                 rresp,
  // One servo pulse per ESC, bit 0 is motor 1
  output logic [3:0]                 motor_pwm
);

  // One channel per rate field
  localparam int num_motors = $bits(motor_rates_t) / rate_width;

  pwm_cfg_t                                staged_cfg;
  pwm_cfg_t                                active_cfg;
  frame_pos_t                              pos;
  logic [31:0]                             frame_count;
  logic [num_motors-1:0][rate_width-1:0]   rate_vec;

  // m1 in the low bits, so rate_vec[0] is motor 1
  assign rate_vec = active_cfg.rates;

  axil_rate_regs u_regs (
    .us_clk      (us_clk),
    .resetn      (resetn),
    .awvalid     (awvalid),
    .awready     (awready),
    .aw          (aw),
    .wvalid      (wvalid),
    .wready      (wready),
    .w           (w),
    .bvalid      (bvalid),
    .bready      (bready),
    .bresp       (bresp),
    .arvalid     (arvalid),
    .arready     (arready),
    .ar          (ar),
    .rvalid      (rvalid),
    .rready      (rready),
    .rdata       (rdata),
    .rresp       (rresp),
    .frame_count (frame_count),
    .staged_cfg  (staged_cfg)
  );

  rate_shadow_buffer u_shadow (
    .us_clk     (us_clk),
    .resetn     (resetn),
    .staged_cfg (staged_cfg),
    .pos        (pos),
    .active_cfg (active_cfg)
  );

  pwm_frame_timer #(
    .period_us   (period_us),
    .min_high_us (min_high_us)
  ) u_timer (
    .us_clk      (us_clk),
    .resetn      (resetn),
    .pos         (pos),
    .frame_count (frame_count)
  );

  // Shared counters, per-motor rate, common arm bit
  for (genvar i = 0; i < num_motors; i++) begin : g_motor
    pwm_channel #(
      .min_high_us (min_high_us)
    ) u_channel (
      .us_clk (us_clk),
      .resetn (resetn),
      .pos    (pos),
      .rate   (rate_vec[i]),
      .armed  (active_cfg.armed),
      .pwm    (motor_pwm[i])
    );
  end

endmodule

`default_nettype wire

/* src/pwm_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module pwm_channel
  import pwm_timing_pkg::*;
#(
  parameter int min_high_us = default_min_high_us
) (
  input  logic                  us_clk,
  input  logic                  resetn,
  input  frame_pos_t            pos,
  input  logic [rate_width-1:0] rate,
  input  logic                  armed,
  output logic                  pwm
);

  localparam logic [cnt_width-1:0] high_start = cnt_width'(min_high_us);

  logic [cnt_width-1:0] rate_cycles;
  logic                 in_fixed;
  logic                 in_extra;
  logic                 pwm_next;

  // Extra pulse length for this motor
  assign rate_cycles = scale_rate(rate);

  // Counts 1 through min_high_us
  assign in_fixed = (pos.period_count != '0) && (pos.period_count <= high_start);

  // high_count is stale before min_high_us+1, gate it off
  assign in_extra = (pos.period_count > high_start) && (pos.high_count < rate_cycles);

  assign pwm_next = armed && (in_fixed || in_extra);

  // Registered output, one cycle behind the count
  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      pwm <= 1'b0;
    end else begin
      pwm <= pwm_next;
    end
  end

endmodule

`default_nettype wire

/* src/pwm_frame_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module pwm_frame_timer
  import pwm_timing_pkg::*;
#(
  parameter int period_us   = default_period_us,
  parameter int min_high_us = default_min_high_us
) (
  input  logic        us_clk,
  input  logic        resetn,
  output frame_pos_t  pos,
  output logic [31:0] frame_count
);

  // Last count before wrap
  localparam logic [cnt_width-1:0] last_count = cnt_width'(period_us - 1);
  // End of the fixed leading part
  localparam logic [cnt_width-1:0] high_start = cnt_width'(min_high_us);

  logic [cnt_width-1:0] period_count;
  logic [cnt_width-1:0] high_count;
  logic                 high_count_en;
  logic                 frame_start;

  assign frame_start = (period_count == '0);

  // Period and high counters
  // high_count is 0 on count min_high_us+1, then counts up
  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      period_count  <= '0;
      high_count    <= '0;
      high_count_en <= 1'b0;
    end else if (period_count == last_count) begin
      // Wrap, new frame
      period_count  <= '0;
      high_count    <= '0;
      high_count_en <= 1'b0;
    end else begin
      period_count <= period_count + 1'b1;
      if (period_count == high_start) begin
        high_count_en <= 1'b1;
      end
      if (high_count_en) begin
        high_count <= high_count + 1'b1;
      end
    end
  end

  // Frames seen since reset
  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      frame_count <= '0;
    end else if (frame_start) begin
      frame_count <= frame_count + 32'd1;
    end
  end

  assign pos = '{period_count: period_count, high_count: high_count, frame_start: frame_start};

endmodule

`default_nettype wire

/* src/rate_shadow_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module rate_shadow_buffer
  import pwm_timing_pkg::*, esc_regs_pkg::*;
(
  input  logic       us_clk,
  input  logic       resetn,
  // Values last written by the host
  input  pwm_cfg_t   staged_cfg,
  // Frame position from the timer
  input  frame_pos_t pos,
  // Values in force for the current frame
  output pwm_cfg_t   active_cfg
);

  // Capture strobe, once per frame
  logic take_cfg;

  assign take_cfg = pos.frame_start;

  // Shadow copy of the whole configuration
  // Written at the end of count 0, so count 0 still runs
  // on the previous frame's values
  // From count 1 the new values hold until the next frame start
  // Host writes in between only touch the staged side
  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      // Disarmed with zero rates out of reset
      active_cfg <= '0;
    end else if (take_cfg) begin
      active_cfg <= staged_cfg;
    end
  end

endmodule

`default_nettype wire

/* src/axil_rate_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_rate_regs
  import pwm_timing_pkg::*, esc_regs_pkg::*;
(
  input  logic                       us_clk,
  input  logic                       resetn,
  // Write address and data
  input  logic                       awvalid,
  output logic                       awready,
  input  axil_aw_t                   aw,
  input  logic                       wvalid,
  output logic                       wready,
  input  axil_w_t                    w,
  // Write response
  output logic                       bvalid,
  input  logic                       bready,
  output axil_resp_e                 bresp,
  // Read address
  input  logic                       arvalid,
  output logic                       arready,
  input  axil_ar_t                   ar,
  // Read data
  output logic                       rvalid,
  input  logic                       rready,
  output logic [axil_data_width-1:0] rdata,
  output axil_resp_e                 rresp,
  // Status from the frame timer
  input  logic [31:0]                frame_count,
  // Staged configuration to the shadow buffer
  output pwm_cfg_t                   staged_cfg
);

  typedef enum logic {W_IDLE, W_RESP} w_state_e;
  typedef enum logic {R_IDLE, R_DATA} r_state_e;

  w_state_e                   w_state;
  r_state_e                   r_state;
  reg_sel_e                   w_sel;
  reg_sel_e                   r_sel;
  logic                       w_fire;
  logic                       r_fire;
  logic [axil_data_width-1:0] r_mux;

  assign w_sel = decode_addr(aw.addr);
  assign r_sel = decode_addr(ar.addr);

  // awready only ever pulses in W_IDLE
  assign w_fire = awready && wready && awvalid && wvalid;
  assign r_fire = arready && arvalid;

  assign bvalid = (w_state == W_RESP);
  assign rvalid = (r_state == R_DATA);

  // Write FSM and staged registers
  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      w_state    <= W_IDLE;
      awready    <= 1'b0;
      wready     <= 1'b0;
      staged_cfg <= '0;
    end else begin
      // Ready is a single-cycle pulse
      awready <= 1'b0;
      wready  <= 1'b0;
      case (w_state)
        W_IDLE: begin
          if (w_fire) begin
            w_state <= W_RESP;
            case (w_sel)
              REG_MOTOR1: staged_cfg.rates.m1 <= w.data[rate_width-1:0];
              REG_MOTOR2: staged_cfg.rates.m2 <= w.data[rate_width-1:0];
              REG_MOTOR3: staged_cfg.rates.m3 <= w.data[rate_width-1:0];
              REG_MOTOR4: staged_cfg.rates.m4 <= w.data[rate_width-1:0];
              REG_CTRL:   staged_cfg.armed <= w.data[0];
              // Status and unmapped leave state alone
              default:    staged_cfg <= staged_cfg;
            endcase
          end else if (awvalid && wvalid) begin
            // Both halves present, accept next cycle
            awready <= 1'b1;
            wready  <= 1'b1;
          end
        end
        W_RESP: begin
          if (bready) begin
            w_state <= W_IDLE;
          end
        end
        default: w_state <= W_IDLE;
      endcase
    end
  end

  // Response code captured with the write
  always_ff @(posedge us_clk) begin
    if (w_fire) begin
      if (w_sel inside {REG_MOTOR1, REG_MOTOR2, REG_MOTOR3, REG_MOTOR4, REG_CTRL}) begin
        bresp <= OKAY;
      end else begin
        bresp <= SLVERR;
      end
    end
  end

  // Read FSM
  // arready held low for the first cycle out of reset
  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      r_state <= R_IDLE;
      arready <= 1'b0;
    end else begin
      case (r_state)
        R_IDLE: begin
          if (r_fire) begin
            r_state <= R_DATA;
            arready <= 1'b0;
          end else begin
            arready <= 1'b1;
          end
        end
        R_DATA: begin
          if (rready) begin
            r_state <= R_IDLE;
            arready <= 1'b1;
          end
        end
        default: r_state <= R_IDLE;
      endcase
    end
  end

  // Readback mux
  always_comb begin
    case (r_sel)
      REG_MOTOR1: r_mux = axil_data_width'(staged_cfg.rates.m1);
      REG_MOTOR2: r_mux = axil_data_width'(staged_cfg.rates.m2);
      REG_MOTOR3: r_mux = axil_data_width'(staged_cfg.rates.m3);
      REG_MOTOR4: r_mux = axil_data_width'(staged_cfg.rates.m4);
      REG_CTRL:   r_mux = axil_data_width'(staged_cfg.armed);
      REG_STATUS: r_mux = frame_count;
      default:    r_mux = '0;
    endcase
  end

  // Read data held until rready
  always_ff @(posedge us_clk) begin
    if (r_fire) begin
      rdata <= r_mux;
      rresp <= (r_sel == REG_NONE) ? SLVERR : OKAY;
    end
  end

endmodule

`default_nettype wire

/* src/esc_regs_pkg.sv */
`default_nettype none

package esc_regs_pkg;

  import pwm_timing_pkg::*;

  localparam int axil_addr_width = 32;
  localparam int axil_data_width = 32;

  // Register select after address decode
  typedef enum logic [2:0] {
    REG_MOTOR1,
    REG_MOTOR2,
    REG_MOTOR3,
    REG_MOTOR4,
    REG_CTRL,
    REG_STATUS,
    REG_NONE
  } reg_sel_e;

  // AXI response codes, EXOKAY and DECERR unused
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axil_resp_e;

  typedef struct packed {
    logic [axil_addr_width-1:0] addr;
  } axil_aw_t;

  typedef struct packed {
    logic [axil_data_width-1:0] data;
  } axil_w_t;

  typedef struct packed {
    logic [axil_addr_width-1:0] addr;
  } axil_ar_t;

  // m1 sits in the low bits so the fields index as an array
  typedef struct packed {
    logic [rate_width-1:0] m4;
    logic [rate_width-1:0] m3;
    logic [rate_width-1:0] m2;
    logic [rate_width-1:0] m1;
  } motor_rates_t;

  // Full drive configuration moved at each frame start
  typedef struct packed {
    motor_rates_t rates;
    logic         armed;
  } pwm_cfg_t;

  // Byte address to register select
  function automatic reg_sel_e decode_addr(input logic [axil_addr_width-1:0] addr);
    reg_sel_e sel;
    case (addr)
      32'h0000_0000: sel = REG_MOTOR1;
      32'h0000_0004: sel = REG_MOTOR2;
      32'h0000_0008: sel = REG_MOTOR3;
      32'h0000_000C: sel = REG_MOTOR4;
      32'h0000_0010: sel = REG_CTRL;
      32'h0000_0014: sel = REG_STATUS;
      default:       sel = REG_NONE;
    endcase
    return sel;
  endfunction

endpackage

`default_nettype wire

/* src/pwm_timing_pkg.sv */
`default_nettype none

package pwm_timing_pkg;

  // Width of one motor rate as written by the host
  localparam int rate_width = 8;

  // One rate step is worth four microseconds of pulse
  localparam int rate_scale_shift = 2;

  // Frame length in us_clk cycles (1 cycle = 1 us)
  localparam int default_period_us = 2040;

  // Fixed leading part of every armed pulse
  localparam int default_min_high_us = 1000;

  // Width of the shared frame counters
  // Must hold period_us - 1
  localparam int cnt_width = 16;

  // Scaled rate width, the extra part of a pulse
  localparam int rate_scaled_width = rate_width + rate_scale_shift;

  // Position inside the current frame, shared by buffer and channels
  typedef struct packed {
    // Cycle within the frame, 0 to period_us-1
    logic [cnt_width-1:0] period_count;
    // Cycles since the fixed part ended
    logic [cnt_width-1:0] high_count;
    // High on count zero only
    logic                 frame_start;
  } frame_pos_t;

  // Scale one rate into counter cycles
  function automatic logic [cnt_width-1:0] scale_rate(input logic [rate_width-1:0] rate);
    logic [cnt_width-1:0] wide;
    wide = cnt_width'(rate);
    return wide << rate_scale_shift;
  endfunction

endpackage

`default_nettype wire
